/* design/step_pkg.sv */
package step_pkg;

   // ==============================
   // Widths
   // ==============================

   localparam int DATA_W     = 8;    // Register value / UART byte
   localparam int INST_W     = 8;    // Switch instruction word
   localparam int REG_ID_W   = 2;
   localparam int NUM_REGS   = 4;
   localparam int IMM_W      = 4;    // LOAD immediate, bits 3..0

   typedef logic [DATA_W-1:0]   data_t;
   typedef logic [INST_W-1:0]   inst_t;
   typedef logic [REG_ID_W-1:0] reg_id_t;

   // ==============================
   // Opcodes, inst bits 7..6
   // ==============================

   typedef enum logic [1:0] {
      OP_LOAD = 2'b00,               // rd = zext(imm)
      OP_ADD  = 2'b01,               // rd = ra + rb
      OP_XOR  = 2'b10,               // rd = ra ^ rb
      OP_SEND = 2'b11                // Queue rd for UART
   } opcode_e;

   // Send handoff toward the UART
   typedef enum logic [1:0] {
      IDLE,
      PENDING,
      WAIT_BUSY
   } seq_state_e;

   // ==============================
   // Timing, kept small for sim
   // ==============================

   localparam int CE_DIV_W   = 4;    // Enable every 2**CE_DIV_W cycles
   localparam int BAUD_DIV   = 8;    // Clocks per UART bit
   localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
   localparam int FRAME_BITS = 10;   // Start + 8 data + stop
   localparam int BIT_IDX_W  = $clog2(FRAME_BITS);

endpackage

/* design/step_input.sv */
`timescale 1ns/1ps

module step_input
(
   input  logic            clk,
   input  logic            arst_i,        // Board reset button
   input  logic            i_btn_step,
   input  logic            i_btn_send,
   input  step_pkg::inst_t i_sw,
   output logic            o_rst,         // Synchronous reset for the rest
   output step_pkg::inst_t o_inst,
   output logic            o_step_pulse,
   output logic            o_send_pulse
);

   import step_pkg::*;

   logic [1:0]          rst_ff;
   logic [CE_DIV_W-1:0] div_cnt;
   logic [CE_DIV_W:0]   div_inc;       // Extra bit is the carry
   logic                ce;            // Sampling enable
   logic                ce_d;          // Enable one cycle later
   logic [2:0]          step_sr;       // [0] is the oldest sample
   logic [2:0]          send_sr;
   logic                step_rise;
   logic                send_rise;

   // ==============================
   // Reset release
   // ==============================

   // Set at once, cleared two edges after arst_i drops
   always_ff @(posedge clk or posedge arst_i)
   begin
      if (arst_i)
         rst_ff <= 2'b11;
      else
         rst_ff <= {1'b0, rst_ff[1]};
   end

   assign o_rst = rst_ff[0];

   // ==============================
   // Sampling enable
   // ==============================

   assign div_inc = {1'b0, div_cnt} + 1'b1;

   always_ff @(posedge clk)
   begin
      if (o_rst)
      begin
         div_cnt <= '0;
         ce      <= 1'b0;
         ce_d    <= 1'b0;
      end
      else
      begin
         div_cnt <= div_inc[CE_DIV_W-1:0];
         ce      <= div_inc[CE_DIV_W];   // Carry out, one cycle wide
         ce_d    <= ce;
      end
   end

   // ==============================
   // Button sampling
   // ==============================

   always_ff @(posedge clk)
   begin
      if (o_rst)
      begin
         o_inst  <= '0;
         step_sr <= '0;
         send_sr <= '0;
      end
      else if (ce)                         // Slow sampling debounces
      begin
         o_inst  <= i_sw;
         step_sr <= {i_btn_step, step_sr[2:1]};
         send_sr <= {i_btn_send, send_sr[2:1]};
      end
   end

   // Rising edge seen in the two oldest samples
   assign step_rise = step_sr[1] & ~step_sr[0];
   assign send_rise = send_sr[1] & ~send_sr[0];

   // One-cycle strobes, only on the delayed enable
   always_ff @(posedge clk)
   begin
      if (o_rst)
      begin
         o_step_pulse <= 1'b0;
         o_send_pulse <= 1'b0;
      end
      else
      begin
         o_step_pulse <= ce_d & step_rise;
         o_send_pulse <= ce_d & send_rise;
      end
   end

endmodule

/* design/seq_core.sv */
`timescale 1ns/1ps

module seq_core
(
   input  logic              clk,
   input  logic              i_rst,
   input  step_pkg::inst_t   i_inst,
   input  logic              i_step_pulse,   // Execute i_inst
   input  logic              i_send_pulse,   // Send register i_sw_reg
   input  step_pkg::reg_id_t i_sw_reg,
   input  logic              i_tx_busy,
   output step_pkg::data_t   o_tx_data,
   output logic              o_tx_stb,
   output step_pkg::data_t   o_led           // Accepted step count
);

   import step_pkg::*;

   data_t      regs [NUM_REGS];
   opcode_e    op;
   reg_id_t    rd;
   reg_id_t    ra;
   reg_id_t    rb;
   logic       wr_en;
   data_t      wr_data;
   logic       req;               // Send request this cycle
   reg_id_t    req_reg;
   logic       accept;
   logic       pend_vld;          // Byte waiting for the UART
   data_t      pend_data;
   logic       seen_busy;         // Busy has risen since the strobe
   seq_state_e state;
   seq_state_e state_nxt;

   // ==============================
   // Decode and execute
   // ==============================

   assign op = opcode_e'(i_inst[7:6]);
   assign rd = i_inst[5:4];
   assign ra = i_inst[3:2];
   assign rb = i_inst[1:0];

   always_comb
   begin
      wr_en   = i_step_pulse && (op != OP_SEND);
      wr_data = '0;
      case (op)
         OP_LOAD: wr_data = data_t'(i_inst[IMM_W-1:0]);   // Zero-extended
         OP_ADD:  wr_data = regs[ra] + regs[rb];          // Wraps at 256
         OP_XOR:  wr_data = regs[ra] ^ regs[rb];
         default: wr_data = '0;                           // SEND writes nothing
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (i_rst)
      begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;
      end
      else if (wr_en)
         regs[rd] <= wr_data;
   end

   // Step counter on the LEDs
   always_ff @(posedge clk)
   begin
      if (i_rst)
         o_led <= '0;
      else if (i_step_pulse)
         o_led <= o_led + 1'b1;
   end

   // ==============================
   // Send queue, one deep
   // ==============================

   assign req     = (i_step_pulse && (op == OP_SEND)) || i_send_pulse;
   assign req_reg = i_send_pulse ? i_sw_reg : rd;   // Button takes the switches

   // Dropped while pending, or until busy has answered the strobe
   assign accept = req && !pend_vld &&
                   ((state == IDLE) || ((state == WAIT_BUSY) && seen_busy));

   assign o_tx_stb  = (state == PENDING) && !i_tx_busy;
   assign o_tx_data = pend_data;

   always_comb
   begin
      state_nxt = state;
      case (state)
         IDLE:
            if (accept)
               state_nxt = PENDING;
         PENDING:
            if (!i_tx_busy)
               state_nxt = WAIT_BUSY;       // Strobe goes out now
         WAIT_BUSY:
            if (seen_busy && !i_tx_busy)    // Frame done
               state_nxt = (pend_vld || accept) ? PENDING : IDLE;
         default:
            state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (i_rst)
      begin
         state     <= IDLE;
         pend_vld  <= 1'b0;
         seen_busy <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (accept)
            pend_vld <= 1'b1;
         else if (o_tx_stb)
            pend_vld <= 1'b0;               // UART has the byte
         if (o_tx_stb)
            seen_busy <= 1'b0;
         else if ((state == WAIT_BUSY) && i_tx_busy)
            seen_busy <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         pend_data <= regs[req_reg];
   end

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
(
   input  logic            clk,
   input  logic            i_rst,
   input  step_pkg::data_t i_data,
   input  logic            i_stb,     // Load and start a frame
   output logic            o_tx,      // Serial line, idles high
   output logic            o_busy
);

   import step_pkg::*;

   logic [BAUD_CNT_W-1:0] baud_cnt;
   logic [BIT_IDX_W-1:0]  bit_idx;
   logic [FRAME_BITS-1:0] frame;     // [0] is on the line
   logic                  baud_end;
   logic                  last_bit;

   assign baud_end = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));
   assign last_bit = (bit_idx == BIT_IDX_W'(FRAME_BITS - 1));

   // ==============================
   // Frame shifter
   // ==============================

   always_ff @(posedge clk)
   begin
      if (i_rst)
      begin
         frame    <= '1;             // Line high
         o_busy   <= 1'b0;
         baud_cnt <= '0;
         bit_idx  <= '0;
      end
      else if (!o_busy)
      begin
         if (i_stb)
         begin
            frame    <= {1'b1, i_data, 1'b0};   // Stop, data LSB first, start
            o_busy   <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
         end
      end
      else if (baud_end)             // End of one bit time
      begin
         baud_cnt <= '0;
         frame    <= {1'b1, frame[FRAME_BITS-1:1]};   // Back-fill ones
         if (last_bit)
            o_busy <= 1'b0;          // Stop bit done
         else
            bit_idx <= bit_idx + 1'b1;
      end
      else
         baud_cnt <= baud_cnt + 1'b1;
   end

   // Strobes during a frame fall through the branches above
   assign o_tx = frame[0];

endmodule

/* design/step_top.sv */
`timescale 1ns/1ps

module step_top
(
   input  logic            clk,
   input  logic            arst_i,
   input  step_pkg::inst_t i_sw,          // Instruction switches
   input  logic            i_btn_step,
   input  logic            i_btn_send,
   output logic            o_tx,          // UART TX pin
   output step_pkg::data_t o_led
);

   import step_pkg::*;

   logic    rst_s;
   inst_t   inst;
   logic    step_pulse;
   logic    send_pulse;
   data_t   tx_data;
   logic    tx_stb;
   logic    tx_busy;
   reg_id_t sw_reg;

   assign sw_reg = inst[5:4];   // Register pick for the send button

   // ==============================
   // Input side
   // ==============================

   step_input u_step_input
   (
      .clk          (clk),
      .arst_i       (arst_i),
      .i_btn_step   (i_btn_step),
      .i_btn_send   (i_btn_send),
      .i_sw         (i_sw),
      .o_rst        (rst_s),
      .o_inst       (inst),
      .o_step_pulse (step_pulse),
      .o_send_pulse (send_pulse)
   );

   // Sequencer
   seq_core u_seq_core
   (
      .clk          (clk),
      .i_rst        (rst_s),
      .i_inst       (inst),
      .i_step_pulse (step_pulse),
      .i_send_pulse (send_pulse),
      .i_sw_reg     (sw_reg),
      .i_tx_busy    (tx_busy),
      .o_tx_data    (tx_data),
      .o_tx_stb     (tx_stb),
      .o_led        (o_led)
   );

   // ==============================
   // Output side
   // ==============================

   uart_tx u_uart_tx
   (
      .clk    (clk),
      .i_rst  (rst_s),
      .i_data (tx_data),
      .i_stb  (tx_stb),
      .o_tx   (o_tx),
      .o_busy (tx_busy)
   );

endmodule

/* dv/step_properties.sv */
`timescale 1ns/1ps

module step_properties
(
   input logic            clk,
   input logic            i_rst,     // Synchronous reset inside the DUT
   input logic            i_tx,      // Serial line
   input step_pkg::data_t i_led,
   input logic            i_busy,    // UART busy level
   input logic            i_stb      // Sequencer strobe toward the UART
);

   import step_pkg::*;

   int unsigned fail_cnt;            // Failed properties so far

   initial
      fail_cnt = 0;

   // ==============================
   // Reset values
   // ==============================

   a_tx_idle_in_reset: assert property (@(posedge clk) $past(i_rst) |-> i_tx)
      else
      begin
         fail_cnt++;
         $error("o_tx low while reset held");
      end

   a_led_zero_in_reset: assert property (@(posedge clk) $past(i_rst) |-> (i_led == '0))
      else
      begin
         fail_cnt++;
         $error("o_led not zero in reset");
      end

   // LEDs only count up by one
   a_led_step: assert property (@(posedge clk) disable iff (i_rst)
      (i_led != $past(i_led)) |-> (i_led == data_t'($past(i_led) + 8'd1)))
      else
      begin
         fail_cnt++;
         $error("o_led changed by other than +1");
      end

   // Strobe starts a frame on the next cycle
   a_stb_starts_frame: assert property (@(posedge clk) disable iff (i_rst)
      i_stb |=> (i_busy && !i_tx))
      else
      begin
         fail_cnt++;
         $error("tx strobe did not start a frame");
      end

   // ==============================
   // Frame shape
   // ==============================

   // Start bit low at its middle and end
   a_start_low: assert property (@(posedge clk) disable iff (i_rst)
      ($fell(i_tx) && !$past(i_busy)) |->
         ##(BAUD_DIV / 2) !i_tx ##(BAUD_DIV / 2 - 1) !i_tx)
      else
      begin
         fail_cnt++;
         $error("start bit shorter than one bit time");
      end

   // Stop bit high at its start and end
   a_stop_high: assert property (@(posedge clk) disable iff (i_rst)
      ($fell(i_tx) && !$past(i_busy)) |->
         ##(BAUD_DIV * 9) i_tx ##(BAUD_DIV - 1) i_tx)
      else
      begin
         fail_cnt++;
         $error("stop bit not high for one bit time");
      end

endmodule

/* dv/tb_step_top.sv */
`timescale 1ns/1ps

module tb_step_top;

   import step_pkg::*;

   localparam int          HOLD      = 64;      // Cycles held, then released
   localparam int          NUM_SEQ   = 6;       // Random op sequences
   localparam int          NUM_PRESS = NUM_SEQ * 4 + NUM_REGS + 2;
   localparam int          NUM_SEND  = NUM_SEQ + NUM_REGS + 2;
   localparam int          CYC_LIMIT = NUM_PRESS * 128 + NUM_SEND * 200 + 500;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   logic  clk;
   logic  arst_i;
   inst_t i_sw;
   logic  i_btn_step;
   logic  i_btn_send;
   logic  o_tx;
   data_t o_led;

   data_t       model_regs [NUM_REGS];   // Reference register file
   data_t       model_led;
   data_t       exp_q [$];               // Bytes still owed by the UART
   logic [31:0] lfsr;
   int          value_errs;
   int          other_errs;
   int          cycles;

   step_top dut0 (.clk(clk), .arst_i(arst_i), .i_sw(i_sw), .i_btn_step(i_btn_step),
                  .i_btn_send(i_btn_send), .o_tx(o_tx), .o_led(o_led));

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;            // 100 ns period
   end

   // Watchdog
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles == CYC_LIMIT)
      begin
         $display("Run stopped at the limit of %0d cycles", CYC_LIMIT);
         print_counts();
         $display("test failed");
         $finish;
      end
   end

   // ==============================
   // Helpers
   // ==============================

   // Galois LFSR, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
         bits = {bits[30:0], lfsr[0]};
      end
      return bits;
   endfunction

   task automatic check_byte(input string name, input data_t got, input data_t exp);
      assert (got == exp)
      else
      begin
         value_errs++;
         $display("ERROR %s: got 8'h%h, expected 8'h%h", name, got, exp);
      end
   endtask

   task automatic print_counts();
      $display("Errors: %0d value, %0d other, %0d property",
               value_errs, other_errs, dut0.props0.fail_cnt);
   endtask

   // Switches and one button together
   task automatic press(input inst_t sw, input logic use_send);
      @(posedge clk);
      i_sw <= sw;
      if (use_send)
         i_btn_send <= 1'b1;
      else
         i_btn_step <= 1'b1;
      repeat (HOLD) @(posedge clk);
      i_btn_step <= 1'b0;
      i_btn_send <= 1'b0;
      repeat (HOLD) @(posedge clk);
   endtask

   // Model update, then the step press
   task automatic run_step(input inst_t inst);
      reg_id_t rd;
      rd = inst[5:4];
      case (opcode_e'(inst[7:6]))
         OP_LOAD: model_regs[rd] = data_t'(inst[3:0]);
         OP_ADD:  model_regs[rd] = model_regs[inst[3:2]] + model_regs[inst[1:0]];
         OP_XOR:  model_regs[rd] = model_regs[inst[3:2]] ^ model_regs[inst[1:0]];
         default: exp_q.push_back(model_regs[rd]);         // SEND
      endcase
      model_led = model_led + 8'd1;
      press(inst, 1'b0);
      check_byte("o_led", o_led, model_led);
   endtask

   // SEND step, then send button while the first frame is on the line
   task automatic send_pair(input reg_id_t ra, input reg_id_t rb);
      exp_q.push_back(model_regs[ra]);
      exp_q.push_back(model_regs[rb]);
      model_led = model_led + 8'd1;
      @(posedge clk);
      i_sw       <= {OP_SEND, ra, 4'h0};
      i_btn_step <= 1'b1;
      repeat (48) @(posedge clk);        // Step pulse is out by now
      i_sw       <= {OP_LOAD, rb, 4'h0};   // Register pick for the button
      i_btn_send <= 1'b1;
      repeat (16) @(posedge clk);
      i_btn_step <= 1'b0;
      repeat (48) @(posedge clk);
      i_btn_send <= 1'b0;
      repeat (HOLD) @(posedge clk);
      check_byte("o_led", o_led, model_led);
   endtask

   // ==============================
   // Serial monitor
   // ==============================

   initial
   begin
      data_t rx;
      wait (arst_i === 1'b1);
      wait (arst_i === 1'b0);
      repeat (4) @(posedge clk);
      forever
      begin
         @(posedge clk);
         if (o_tx === 1'b0)                          // Start bit
         begin
            repeat (BAUD_DIV / 2) @(posedge clk);    // Mid start bit
            for (int i = 0; i < DATA_W; i++)
            begin
               repeat (BAUD_DIV) @(posedge clk);
               rx[i] = o_tx;                         // LSB first
            end
            repeat (BAUD_DIV) @(posedge clk);        // Mid stop bit
            if (exp_q.size() == 0)
            begin
               other_errs++;
               $display("Byte %h arrived on o_tx while none was expected", rx);
            end
            else
               check_byte("o_tx byte", rx, exp_q.pop_front());
         end
      end
   end

   // ==============================
   // Stimulus
   // ==============================

   initial
   begin
      reg_id_t rd;
      reg_id_t ra;
      reg_id_t rb;
      opcode_e op;
      arst_i     = 1'b1;
      i_sw       = '0;
      i_btn_step = 1'b0;
      i_btn_send = 1'b0;
      lfsr       = 32'h470e_5988;
      value_errs = 0;
      other_errs = 0;
      cycles     = 0;
      model_led  = '0;
      for (int r = 0; r < NUM_REGS; r++)
         model_regs[r] = '0;
      repeat (5) @(posedge clk);
      arst_i <= 1'b0;
      repeat (4) @(posedge clk);
      check_byte("o_tx", data_t'(o_tx), 8'h01);     // Line idles high
      check_byte("o_led", o_led, 8'h00);

      // Two random loads, ADD or XOR, then SEND
      for (int k = 0; k < NUM_SEQ; k++)
      begin
         rd = reg_id_t'(take_bits(2));
         ra = reg_id_t'(take_bits(2));
         rb = reg_id_t'(take_bits(2));
         op = (k % 2 == 0) ? OP_ADD : OP_XOR;
         run_step({OP_LOAD, ra, 4'(take_bits(4))});
         run_step({OP_LOAD, rb, 4'(take_bits(4))});
         run_step({op, rd, ra, rb});
         run_step({OP_SEND, rd, 4'h0});
      end

      // Send button on each register
      for (int r = 0; r < NUM_REGS; r++)
      begin
         exp_q.push_back(model_regs[r]);
         press({OP_LOAD, reg_id_t'(r), 4'h0}, 1'b1);
      end

      send_pair(2'd1, 2'd2);

      // Drain, then watch for stray frames
      for (int i = 0; i < 4 * BAUD_DIV * FRAME_BITS && exp_q.size() != 0; i++)
         @(posedge clk);
      repeat (2 * BAUD_DIV * FRAME_BITS) @(posedge clk);
      assert (exp_q.size() == 0)
      else
      begin
         other_errs++;
         $display("%0d expected bytes never appeared on o_tx", exp_q.size());
      end

      print_counts();
      if (value_errs + other_errs + int'(dut0.props0.fail_cnt) == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// Frame and LED properties inside the DUT
bind step_top step_properties props0
(
   .clk    (clk),
   .i_rst  (rst_s),
   .i_tx   (o_tx),
   .i_led  (o_led),
   .i_busy (tx_busy),
   .i_stb  (tx_stb)
);

/* compile.f */
design/step_pkg.sv
design/step_input.sv
design/seq_core.sv
design/uart_tx.sv
design/step_top.sv
dv/step_properties.sv
dv/tb_step_top.sv

/* Makefile */
TOOL     = verilator
TOP      = tb_step_top
FILELIST = compile.f
FLAGS    = --binary --assert --timing -Wno-fatal
RUNFLAGS = +verilator+error+limit+1000
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
